/* Makefile */
# Verilator build and run of the image verify testbench

VERILATOR ?= verilator
TOP       ?= image_verify_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/verify_defines.svh */
// image format and CRC constants; changing the word size also needs new source word types
`ifndef VERIFY_DEFINES_SVH
`define VERIFY_DEFINES_SVH

//////////////////////////////
// crc-16
//////////////////////////////

// start value loaded at every accepted start
`define VERIFY_CRC_INIT 16'hffff

// reflected form of x^16 + x^12 + x^5 + 1, shifted lsb first
`define VERIFY_CRC_POLY 16'h8408

//////////////////////////////
// image header layout
//////////////////////////////

// counts above this stop the fetch with an error
`define VERIFY_MAX_COMPONENTS 5'd4

// size low, size high and count words
`define VERIFY_FIXED_HDR_BYTES 32'd6

// two words per component entry
`define VERIFY_COMP_BYTES 32'd4

//////////////////////////////
// source fifo
//////////////////////////////

// one 16-bit source word
`define VERIFY_WORD_BYTES 32'd2

`endif

/* list.f */
+incdir+include
source/image_fmt_pkg.sv
source/fetch_ctrl_pkg.sv
source/crc16_serial.sv
source/image_header_regs.sv
source/image_byte_counter.sv
source/image_fetch_fsm.sv
source/image_verify_top.sv
verification/image_verify_props.sv
verification/image_verify_tb.sv

/* source/crc16_serial.sv */
// reflected crc-16, one bit per clock lsb first, no final xor; crc_start must not overlap a fold
`timescale 1ns/1ps
`include "verify_defines.svh"

module crc16_serial (
	input  logic sys_clk,
	input  logic sys_nrst,
	input  logic init,
	input  logic word_valid,
	input  logic crc_start,
	input  image_fmt_pkg::img_word_t word,
	output logic crc_match,
	output logic crc_done
);

	image_fmt_pkg::img_word_t word_reg;
	logic [15:0] crc;
	logic [3:0] bit_cnt;
	logic running;
	logic feedback;

	assign feedback = crc[0] ^ word_reg[bit_cnt];

	// last of the 16 bit steps
	assign crc_done = running && (bit_cnt == 4'd15);

	always_ff @(posedge sys_clk) begin
		if (word_valid)
			word_reg <= word;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_nrst) begin
			crc <= `VERIFY_CRC_INIT;
			crc_match <= 1'b0;
			running <= 1'b0;
			bit_cnt <= '0;
		end else begin
			if (init)
				crc <= `VERIFY_CRC_INIT;
			else if (running)
				crc <= {1'b0, crc[15:1]} ^ (feedback ? `VERIFY_CRC_POLY : 16'h0000);

			// compare against the crc before this word is folded in
			if (word_valid)
				crc_match <= (crc == word);

			if (crc_start) begin
				running <= 1'b1;
				bit_cnt <= '0;
			end else if (running) begin
				bit_cnt <= bit_cnt + 4'd1;
				if (bit_cnt == 4'd15)
					running <= 1'b0;
			end
		end
	end

endmodule

/* source/fetch_ctrl_pkg.sv */
// fetch controller types; status bits are levels that hold until the next accepted start
package fetch_ctrl_pkg;

	//////////////////////////////
	// fsm states
	//////////////////////////////

	// REQ also covers the capture cycle of a word
	typedef enum logic [2:0] {
		S_IDLE   = 3'd0,
		S_REQ    = 3'd1,
		S_DECIDE = 3'd2,
		S_CRC    = 3'd3
	} fetch_state_e;

	//////////////////////////////
	// status
	//////////////////////////////

	// done and error are exclusive, busy drops when either is set
	typedef struct packed {
		logic busy;
		logic done;
		logic error;
	} verify_status_t;

endpackage

/* source/image_byte_counter.sv */
// classifies the next word from bytes already read; size and count must be loaded before use
`timescale 1ns/1ps
`include "verify_defines.svh"

module image_byte_counter (
	input  logic sys_clk,
	input  logic sys_nrst,
	input  logic clear,
	input  logic word_valid,
	input  image_fmt_pkg::img_size_t img_size,
	input  image_fmt_pkg::comp_count_t comp_count,
	output image_fmt_pkg::word_region_e region_now,
	output image_fmt_pkg::word_region_e word_region
);

	image_fmt_pkg::img_size_t byte_cnt;
	image_fmt_pkg::img_size_t next_cnt;
	image_fmt_pkg::img_size_t hdr_crc_pos;

	// header crc follows the fixed words and the component entries
	assign hdr_crc_pos = `VERIFY_FIXED_HDR_BYTES + (32'(comp_count) * `VERIFY_COMP_BYTES);
	assign next_cnt = byte_cnt + `VERIFY_WORD_BYTES;

	//////////////////////////////
	// region of the next word
	//////////////////////////////

	always_comb begin
		if (byte_cnt == 32'd0)
			region_now = image_fmt_pkg::REG_SIZE_LO;
		else if (byte_cnt == `VERIFY_WORD_BYTES)
			region_now = image_fmt_pkg::REG_SIZE_HI;
		else if (byte_cnt < `VERIFY_FIXED_HDR_BYTES)
			region_now = image_fmt_pkg::REG_COUNT;
		else if (byte_cnt < hdr_crc_pos)
			region_now = image_fmt_pkg::REG_COMPONENT;
		else if (byte_cnt == hdr_crc_pos)
			region_now = image_fmt_pkg::REG_HDR_CRC;
		else if (next_cnt < img_size)
			region_now = image_fmt_pkg::REG_PAYLOAD;
		else
			// the word that reaches the image size
			region_now = image_fmt_pkg::REG_IMG_CRC;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_nrst) begin
			byte_cnt <= '0;
			word_region <= image_fmt_pkg::REG_SIZE_LO;
		end else if (clear) begin
			byte_cnt <= '0;
		end else if (word_valid) begin
			byte_cnt <= next_cnt;
			word_region <= region_now;
		end
	end

endmodule

/* source/image_fetch_fsm.sv */
// one word in flight at a time, 19 cycles per word without stalls; start is ignored while busy
`timescale 1ns/1ps

module image_fetch_fsm (
	input  logic sys_clk,
	input  logic sys_nrst,
	input  logic start,
	input  logic src_empty,
	output logic src_rd_en,
	output logic word_valid,
	output logic clear,
	output logic crc_start,
	input  image_fmt_pkg::word_region_e word_region,
	input  logic count_bad,
	input  logic crc_match,
	input  logic crc_done,
	output fetch_ctrl_pkg::verify_status_t status
);

	fetch_ctrl_pkg::fetch_state_e state;

	logic count_err;
	logic hdr_crc_err;
	logic last_word;

	//////////////////////////////
	// per word decision
	//////////////////////////////

	// word_region, count_bad and crc_match all settle in the capture cycle
	assign count_err   = (word_region == image_fmt_pkg::REG_COUNT) && count_bad;
	assign hdr_crc_err = (word_region == image_fmt_pkg::REG_HDR_CRC) && !crc_match;
	assign last_word   = (word_region == image_fmt_pkg::REG_IMG_CRC);

	// fold every word that does not end the run
	assign crc_start = (state == fetch_ctrl_pkg::S_DECIDE) && !count_err &&
		!hdr_crc_err && !last_word;

	// counter and crc restart together with the run
	assign clear = (state == fetch_ctrl_pkg::S_IDLE) && start;

	// single read per REQ visit, none while the captured word is pending
	assign src_rd_en = (state == fetch_ctrl_pkg::S_REQ) && !word_valid && !src_empty;

	//////////////////////////////
	// state and status
	//////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (!sys_nrst) begin
			state <= fetch_ctrl_pkg::S_IDLE;
			word_valid <= 1'b0;
			status <= '0;
		end else begin
			// fifo data shows up one cycle after the read
			word_valid <= src_rd_en;

			case (state)
				fetch_ctrl_pkg::S_IDLE: begin
					if (start) begin
						status.busy <= 1'b1;
						status.done <= 1'b0;
						status.error <= 1'b0;
						state <= fetch_ctrl_pkg::S_REQ;
					end
				end

				fetch_ctrl_pkg::S_REQ: begin
					if (word_valid)
						state <= fetch_ctrl_pkg::S_DECIDE;
				end

				fetch_ctrl_pkg::S_DECIDE: begin
					if (count_err || hdr_crc_err) begin
						status.busy <= 1'b0;
						status.error <= 1'b1;
						state <= fetch_ctrl_pkg::S_IDLE;
					end else if (last_word) begin
						// running crc against the trailing image crc
						status.busy <= 1'b0;
						status.done <= crc_match;
						status.error <= !crc_match;
						state <= fetch_ctrl_pkg::S_IDLE;
					end else begin
						state <= fetch_ctrl_pkg::S_CRC;
					end
				end

				fetch_ctrl_pkg::S_CRC: begin
					if (crc_done)
						state <= fetch_ctrl_pkg::S_REQ;
				end

				default: begin
					state <= fetch_ctrl_pkg::S_IDLE;
				end
			endcase
		end
	end

endmodule

/* source/image_fmt_pkg.sv */
// image layout types; sizes are byte counts and words arrive low byte first in bits 7:0
package image_fmt_pkg;

	// one word from the source fifo
	typedef logic [15:0] img_word_t;

	// byte count of the whole image, trailing crc word included
	typedef logic [31:0] img_size_t;

	// number of component entries in the header
	typedef logic [4:0] comp_count_t;

	// count word layout, only the low 5 bits carry the count
	typedef struct packed {
		logic [10:0] reserved;
		comp_count_t comp_count;
	} count_view_t;

	// header word seen as raw crc input or as the count field
	typedef union packed {
		img_word_t raw;
		count_view_t count_view;
	} hdr_word_u;

	// position of a word inside the image
	typedef enum logic [2:0] {
		REG_SIZE_LO   = 3'd0,
		REG_SIZE_HI   = 3'd1,
		REG_COUNT     = 3'd2,
		REG_COMPONENT = 3'd3,
		REG_HDR_CRC   = 3'd4,
		REG_PAYLOAD   = 3'd5,
		REG_IMG_CRC   = 3'd6
	} word_region_e;

endpackage

/* source/image_header_regs.sv */
// holds the size and count of the current image only; the count limit is tested nowhere else
`timescale 1ns/1ps
`include "verify_defines.svh"

module image_header_regs (
	input  logic sys_clk,
	input  logic sys_nrst,
	input  logic word_valid,
	input  image_fmt_pkg::word_region_e region_now,
	input  image_fmt_pkg::img_word_t word,
	output image_fmt_pkg::img_size_t img_size,
	output image_fmt_pkg::comp_count_t comp_count,
	output logic count_bad
);

	image_fmt_pkg::hdr_word_u hdr;

	// same bits, read as size half or as count field
	always_comb hdr.raw = word;

	//////////////////////////////
	// header fields
	//////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (word_valid) begin
			case (region_now)
				image_fmt_pkg::REG_SIZE_LO: img_size[15:0] <= hdr.raw;
				image_fmt_pkg::REG_SIZE_HI: img_size[31:16] <= hdr.raw;
				image_fmt_pkg::REG_COUNT:   comp_count <= hdr.count_view.comp_count;
				default: ;
			endcase
		end
	end

	// limit check on the count word, read by the fsm in DECIDE
	always_ff @(posedge sys_clk) begin
		if (!sys_nrst)
			count_bad <= 1'b0;
		else if (word_valid && (region_now == image_fmt_pkg::REG_COUNT))
			count_bad <= (hdr.count_view.comp_count > `VERIFY_MAX_COMPONENTS);
	end

endmodule

/* source/image_verify_top.sv */
// source fifo must present data one cycle after src_rd_en; start is a single-cycle pulse
`timescale 1ns/1ps

module image_verify_top (
	input  logic sys_clk,
	input  logic sys_nrst,
	input  logic start,
	input  logic src_empty,
	input  image_fmt_pkg::img_word_t src_data,
	output logic src_rd_en,
	output fetch_ctrl_pkg::verify_status_t status
);

	logic word_valid;
	logic clear;
	logic crc_start;
	logic count_bad;
	logic crc_match;
	logic crc_done;
	image_fmt_pkg::word_region_e region_now;
	image_fmt_pkg::word_region_e word_region;
	image_fmt_pkg::img_size_t img_size;
	image_fmt_pkg::comp_count_t comp_count;

	//////////////////////////////
	// control
	//////////////////////////////

	image_fetch_fsm i_fsm (
		.sys_clk     (sys_clk),
		.sys_nrst    (sys_nrst),
		.start       (start),
		.src_empty   (src_empty),
		.src_rd_en   (src_rd_en),
		.word_valid  (word_valid),
		.clear       (clear),
		.crc_start   (crc_start),
		.word_region (word_region),
		.count_bad   (count_bad),
		.crc_match   (crc_match),
		.crc_done    (crc_done),
		.status      (status)
	);

	image_byte_counter i_counter (
		.sys_clk     (sys_clk),
		.sys_nrst    (sys_nrst),
		.clear       (clear),
		.word_valid  (word_valid),
		.img_size    (img_size),
		.comp_count  (comp_count),
		.region_now  (region_now),
		.word_region (word_region)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////

	image_header_regs i_header (
		.sys_clk     (sys_clk),
		.sys_nrst    (sys_nrst),
		.word_valid  (word_valid),
		.region_now  (region_now),
		.word        (src_data),
		.img_size    (img_size),
		.comp_count  (comp_count),
		.count_bad   (count_bad)
	);

	// crc restarts with the byte count
	crc16_serial i_crc (
		.sys_clk     (sys_clk),
		.sys_nrst    (sys_nrst),
		.init        (clear),
		.word_valid  (word_valid),
		.crc_start   (crc_start),
		.word        (src_data),
		.crc_match   (crc_match),
		.crc_done    (crc_done)
	);

endmodule

/* verification/image_verify_props.sv */
// checks hold only out of reset and are sampled on the rising clock edge
`timescale 1ns/1ps

module image_verify_props (
	input logic sys_clk,
	input logic sys_nrst,
	input logic start,
	input logic src_empty,
	input logic src_rd_en,
	input fetch_ctrl_pkg::verify_status_t status
);

	// failed assertion count
	int fail_cnt = 0;

	//////////////////////////////
	// source fifo
	//////////////////////////////

	a_no_read_empty: assert property (@(posedge sys_clk) disable iff (!sys_nrst)
		src_rd_en |-> !src_empty)
		else begin
			$error("read enable while the source fifo is empty");
			fail_cnt = fail_cnt + 1;
		end

	// reads only inside a run
	a_no_read_idle: assert property (@(posedge sys_clk) disable iff (!sys_nrst)
		!status.busy |-> !src_rd_en)
		else begin
			$error("read enable while not busy");
			fail_cnt = fail_cnt + 1;
		end

	//////////////////////////////
	// status
	//////////////////////////////

	a_done_xor_error: assert property (@(posedge sys_clk) disable iff (!sys_nrst)
		!(status.done && status.error))
		else begin
			$error("done and error high together");
			fail_cnt = fail_cnt + 1;
		end

	a_start_busy: assert property (@(posedge sys_clk) disable iff (!sys_nrst)
		(start && !status.busy) |=> status.busy)
		else begin
			$error("start while idle did not raise busy");
			fail_cnt = fail_cnt + 1;
		end

endmodule

/* verification/image_verify_tb.sv */
// fifo model answers each read one cycle later; 24 images of up to 21 words each, fixed seed
`timescale 1ns/1ps
`include "verify_defines.svh"

module image_verify_tb;

	localparam int NUM_RUNS = 24;

	logic sys_clk;
	logic sys_nrst;
	logic start;
	logic src_empty;
	image_fmt_pkg::img_word_t src_data;
	logic src_rd_en;
	fetch_ctrl_pkg::verify_status_t status;

	integer seed;
	image_fmt_pkg::img_word_t image_words[$];
	int rd_idx;
	logic rd_pending;
	int stall_pct;
	int run_cycles;
	int run_limit;
	int exp_reads;
	logic exp_done;

	image_verify_top i_dut (
		.sys_clk   (sys_clk),
		.sys_nrst  (sys_nrst),
		.start     (start),
		.src_empty (src_empty),
		.src_data  (src_data),
		.src_rd_en (src_rd_en),
		.status    (status)
	);

	bind image_verify_top image_verify_props i_props (
		.sys_clk   (sys_clk),
		.sys_nrst  (sys_nrst),
		.start     (start),
		.src_empty (src_empty),
		.src_rd_en (src_rd_en),
		.status    (status)
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic image_fmt_pkg::img_word_t rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// reflected crc, lsb of the word first
	function automatic logic [15:0] fold_word(input logic [15:0] crc_in, input logic [15:0] w);
		logic [15:0] c;
		logic fb;
		c = crc_in;
		for (int i = 0; i < 16; i++) begin
			fb = c[0] ^ w[i];
			c = {1'b0, c[15:1]};
			if (fb)
				c = c ^ `VERIFY_CRC_POLY;
		end
		return c;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// kind 0 valid, 1 payload bit flip, 2 bad header crc, 3 count over the limit
	task automatic build_image(input int kind);
		int n_comp;
		int n_pay;
		int size_bytes;
		int hdr_idx;
		int pos;
		int bad_count;
		logic [15:0] crc;
		image_fmt_pkg::hdr_word_u cw;
		image_fmt_pkg::img_word_t flip;

		n_comp = rand_below(int'(`VERIFY_MAX_COMPONENTS) + 1);
		n_pay = (kind == 1) ? 1 + rand_below(8) : rand_below(9);
		size_bytes = int'(`VERIFY_FIXED_HDR_BYTES) + n_comp * int'(`VERIFY_COMP_BYTES) +
			(n_pay + 2) * int'(`VERIFY_WORD_BYTES);
		image_words.delete();
		image_words.push_back(size_bytes[15:0]);
		image_words.push_back(size_bytes[31:16]);
		cw.raw = rand_word();
		cw.count_view.comp_count = n_comp[4:0];
		image_words.push_back(cw.raw);
		repeat (2 * n_comp)
			image_words.push_back(rand_word());
		crc = `VERIFY_CRC_INIT;
		foreach (image_words[i])
			crc = fold_word(crc, image_words[i]);
		// header crc word is folded in as well
		hdr_idx = image_words.size();
		image_words.push_back(crc);
		crc = fold_word(crc, crc);
		repeat (n_pay) begin
			image_words.push_back(rand_word());
			crc = fold_word(crc, image_words[image_words.size() - 1]);
		end
		image_words.push_back(crc);
		exp_reads = image_words.size();
		exp_done = (kind == 0);
		case (kind)
			1: begin
				pos = hdr_idx + 1 + rand_below(n_pay);
				image_words[pos] = image_words[pos] ^ (16'h0001 << rand_below(16));
			end
			2: begin
				flip = rand_word();
				if (flip == 16'h0000)
					flip = 16'h0001;
				image_words[hdr_idx] = image_words[hdr_idx] ^ flip;
				exp_reads = hdr_idx + 1;
			end
			3: begin
				bad_count = int'(`VERIFY_MAX_COMPONENTS) + 1 +
					rand_below(31 - int'(`VERIFY_MAX_COMPONENTS));
				cw.raw = image_words[2];
				cw.count_view.comp_count = bad_count[4:0];
				image_words[2] = cw.raw;
				exp_reads = 3;
			end
			default: ;
		endcase
	endtask

	task automatic pulse_start();
		@(posedge sys_clk);
		#1;
		start = 1'b1;
		@(posedge sys_clk);
		#1;
		start = 1'b0;
	endtask

	task automatic run_image();
		int reads_at_end;

		run_limit = image_words.size() * 40 + 100;
		run_cycles = 0;
		rd_idx = 0;
		pulse_start();
		// second start lands while busy
		repeat (5)
			@(negedge sys_clk);
		check_value("status.busy", 32'(status.busy), 32'd1);
		pulse_start();
		do
			@(negedge sys_clk);
		while (!(status.done || status.error));
		reads_at_end = rd_idx;
		repeat (3)
			@(negedge sys_clk);
		check_value("status.done", 32'(status.done), 32'(exp_done));
		check_value("status.error", 32'(status.error), 32'(!exp_done));
		check_value("status.busy", 32'(status.busy), 32'd0);
		check_value("src_rd_en count", 32'(reads_at_end), 32'(exp_reads));
		check_value("src_rd_en count after result", 32'(rd_idx), 32'(reads_at_end));
	endtask

	//////////////////////////////
	// processes
	//////////////////////////////

	initial begin
		sys_clk = 1'b0;
		forever
			#50 sys_clk = ~sys_clk;
	end

	// source fifo, data one cycle after the read
	initial begin
		src_data = '0;
		src_empty = 1'b1;
		rd_pending = 1'b0;
		forever begin
			@(posedge sys_clk);
			#1;
			if (rd_pending) begin
				src_data = image_words[rd_idx];
				rd_idx = rd_idx + 1;
			end
			src_empty = (rd_idx >= image_words.size()) || (rand_below(100) < stall_pct);
			@(negedge sys_clk);
			rd_pending = src_rd_en;
		end
	end

	// 40 cycles per word of the current image plus a margin
	initial begin
		forever begin
			@(posedge sys_clk);
			run_cycles = run_cycles + 1;
			if (run_cycles > run_limit) begin
				$display("timeout: no result from the DUT after %0d cycles", run_cycles);
				$display("Simulation failed");
				$fatal(1, "watchdog expired");
			end
		end
	end

	initial begin
		seed = 32'h8dafb844;
		sys_nrst = 1'b0;
		start = 1'b0;
		rd_idx = 0;
		stall_pct = 0;
		run_cycles = 0;
		run_limit = 100;
		repeat (8)
			@(posedge sys_clk);
		#1;
		sys_nrst = 1'b1;
		@(negedge sys_clk);
		check_value("src_rd_en", 32'(src_rd_en), 32'd0);
		check_value("status", 32'(status), 32'd0);
		// every kind runs with and without stalls
		for (int run = 0; run < NUM_RUNS; run++) begin
			stall_pct = (((run / 4) % 2) == 1) ? 35 : 0;
			build_image(run % 4);
			run_image();
		end
		if (i_dut.i_props.fail_cnt == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("%0d assertion failures in the DUT checks", i_dut.i_props.fail_cnt);
			$display("Simulation failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule
